/* verilog/atop_pkg.sv */
/*
 * Atomic resolver shared definitions
 * Word geometry, the OBI atop opcode encoding and the sequencer states.
 */

`default_nettype none

package atop_pkg;

  // One RISC-V word per memory access
  localparam int unsigned WordWidth = 32;
  localparam int unsigned BeWidth   = WordWidth / 8;

  // ---------------------------------------------------------------------
  // Atomic opcodes
  // ---------------------------------------------------------------------

  // Bit 5 marks an atomic, the lower bits are the RISC-V AMO funct5
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    AMO_LR    = 6'h22,
    AMO_SC    = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  // ---------------------------------------------------------------------
  // Sequencer states
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {
    IDLE       = 2'b00,
    WRITE_BACK = 2'b01
  } amo_state_e;

endpackage

`default_nettype wire

/* verilog/amo_alu.sv */
/*
 * AMO arithmetic unit
 * Computes the write-back word of the nine read-modify-write atomics.
 */

`timescale 1ns/1ps
`default_nettype none

module amo_alu (
  input  atop_pkg::atop_e                        amo_op_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    operand_a_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    operand_b_i,
  output logic      [atop_pkg::WordWidth-1:0]    result_o
);

  localparam int unsigned W = atop_pkg::WordWidth;

  logic         is_signed;
  logic [W:0]   a_ext, b_ext, diff;
  logic         a_lt_b;

  // One shared subtractor serves all four compares, the extension bit picks
  // between the signed and the unsigned view
  assign is_signed = (amo_op_i == atop_pkg::AMO_MIN) || (amo_op_i == atop_pkg::AMO_MAX);
  assign a_ext     = {is_signed & operand_a_i[W-1], operand_a_i};
  assign b_ext     = {is_signed & operand_b_i[W-1], operand_b_i};
  assign diff      = a_ext - b_ext;
  assign a_lt_b    = diff[W];

  always_comb begin
    unique case (amo_op_i)
      atop_pkg::AMO_SWAP: result_o = operand_b_i;
      atop_pkg::AMO_ADD:  result_o = operand_a_i + operand_b_i;
      atop_pkg::AMO_XOR:  result_o = operand_a_i ^ operand_b_i;
      atop_pkg::AMO_AND:  result_o = operand_a_i & operand_b_i;
      atop_pkg::AMO_OR:   result_o = operand_a_i | operand_b_i;
      atop_pkg::AMO_MIN,
      atop_pkg::AMO_MINU: result_o = a_lt_b ? operand_a_i : operand_b_i;
      atop_pkg::AMO_MAX,
      atop_pkg::AMO_MAXU: result_o = a_lt_b ? operand_b_i : operand_a_i;
      default:            result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/reservation_tracker.sv */
/*
 * LR/SC reservation tracker
 * Keeps one reservation (address and owner ID) and decides whether a
 * store-conditional succeeds. The decision is also registered so that it
 * lines up with the memory response of the accepted request.
 */

`timescale 1ns/1ps
`default_nettype none

module reservation_tracker #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned IdWidth   = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 accept_i,
  input  wire logic [AddrWidth-1:0] addr_i,
  input  wire logic [IdWidth-1:0]   aid_i,
  input  wire logic                 we_i,
  input  atop_pkg::atop_e           atop_i,
  output logic                      sc_pass_o,
  output logic                      sc_q_o,
  output logic                      sc_ok_q_o
);

  logic                 resv_valid_q, resv_valid_d;
  logic [AddrWidth-1:0] resv_addr_q;
  logic [IdWidth-1:0]   resv_owner_q;
  logic                 is_lr, is_sc, is_rmw;
  logic                 same_owner, addr_hit, lr_take, ok_d;

  assign is_lr      = (atop_i == atop_pkg::AMO_LR);
  assign is_sc      = (atop_i == atop_pkg::AMO_SC);
  assign is_rmw     = atop_i[5] && !is_lr && !is_sc;
  assign same_owner = (resv_owner_q == aid_i);
  assign addr_hit   = (resv_addr_q == addr_i);

  // SC succeeds only for the owner of a live reservation on the same word
  assign sc_pass_o = is_sc && resv_valid_q && same_owner && addr_hit;

  // A held reservation is only replaced by its own owner, which avoids live-lock
  assign lr_take = accept_i && is_lr && (!resv_valid_q || same_owner);

  always_comb begin
    resv_valid_d = resv_valid_q;
    ok_d         = 1'b0;
    if (accept_i) begin
      if (lr_take) begin
        resv_valid_d = 1'b1;
        ok_d         = 1'b1;
      end
      // Another requester modifying the reserved word breaks the reservation
      if (!same_owner && addr_hit && (is_rmw || (we_i && !is_sc))) begin
        resv_valid_d = 1'b0;
      end
      // Any SC from the owner consumes the reservation
      if (is_sc && resv_valid_q && same_owner) begin
        resv_valid_d = 1'b0;
        ok_d         = addr_hit;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
      sc_q_o       <= 1'b0;
      sc_ok_q_o    <= 1'b0;
    end else begin
      resv_valid_q <= resv_valid_d;
      sc_q_o       <= accept_i && is_sc;
      sc_ok_q_o    <= ok_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lr_take) begin
      resv_addr_q  <= addr_i;
      resv_owner_q <= aid_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/amo_sequencer.sv */
/*
 * AMO sequencer
 * Forwards plain, LR and SC requests to memory and splits every
 * read-modify-write atomic into a read followed by a write-back.
 */

`timescale 1ns/1ps
`default_nettype none

module amo_sequencer #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned IdWidth   = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              sbr_req_i,
  input  wire logic [AddrWidth-1:0]              sbr_addr_i,
  input  wire logic                              sbr_we_i,
  input  wire logic [atop_pkg::BeWidth-1:0]      sbr_be_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    sbr_wdata_i,
  input  wire logic [IdWidth-1:0]                sbr_aid_i,
  input  atop_pkg::atop_e                        sbr_atop_i,
  input  wire logic                              mem_gnt_i,
  input  wire logic                              mem_rvalid_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    mem_rdata_i,
  input  wire logic                              buf_ready_i,
  input  wire logic                              sc_pass_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    alu_result_i,
  output logic                                   sbr_gnt_o,
  output logic                                   mem_req_o,
  output logic      [AddrWidth-1:0]              mem_addr_o,
  output logic                                   mem_we_o,
  output logic      [atop_pkg::BeWidth-1:0]      mem_be_o,
  output logic      [atop_pkg::WordWidth-1:0]    mem_wdata_o,
  output logic      [IdWidth-1:0]                mem_aid_o,
  output logic                                   accept_o,
  output logic                                   drop_rsp_o,
  output atop_pkg::atop_e                        amo_op_o,
  output logic      [atop_pkg::WordWidth-1:0]    operand_a_o,
  output logic      [atop_pkg::WordWidth-1:0]    operand_b_o
);

  atop_pkg::amo_state_e state_q, state_d;

  logic                           is_sc, is_rmw, load_amo, wb_gnt_q;
  logic [AddrWidth-1:0]           addr_q;
  logic [IdWidth-1:0]             aid_q;
  atop_pkg::atop_e                amo_op_q;
  logic [atop_pkg::WordWidth-1:0] operand_a_q, operand_b_q;

  assign is_sc  = (sbr_atop_i == atop_pkg::AMO_SC);
  assign is_rmw = sbr_atop_i[5] && !is_sc && (sbr_atop_i != atop_pkg::AMO_LR);

  always_comb begin
    // Pass-through while idle, gated on room for the response
    state_d     = state_q;
    load_amo    = 1'b0;
    sbr_gnt_o   = buf_ready_i && mem_gnt_i;
    mem_req_o   = sbr_req_i && buf_ready_i;
    mem_addr_o  = sbr_addr_i;
    mem_we_o    = is_sc ? sc_pass_i : (sbr_we_i && !is_rmw);
    mem_be_o    = sbr_be_i;
    mem_wdata_o = sbr_wdata_i;
    mem_aid_o   = sbr_aid_i;
    accept_o    = sbr_req_i && buf_ready_i && mem_gnt_i;

    unique case (state_q)
      atop_pkg::IDLE: begin
        if (accept_o && is_rmw) begin
          load_amo = 1'b1;
          state_d  = atop_pkg::WRITE_BACK;
        end
      end
      atop_pkg::WRITE_BACK: begin
        // The memory port belongs to the write-back until it is granted
        sbr_gnt_o   = 1'b0;
        accept_o    = 1'b0;
        mem_req_o   = 1'b1;
        mem_addr_o  = addr_q;
        mem_we_o    = 1'b1;
        mem_be_o    = '1;
        mem_wdata_o = alu_result_i;
        mem_aid_o   = aid_q;
        if (mem_gnt_i) begin
          state_d = atop_pkg::IDLE;
        end
      end
      default: state_d = atop_pkg::IDLE;
    endcase
  end

  // Read data of the AMO is used straight from memory in its rvalid cycle
  assign operand_a_o = mem_rvalid_i ? mem_rdata_i : operand_a_q;
  assign operand_b_o = operand_b_q;
  assign amo_op_o    = amo_op_q;
  assign drop_rsp_o  = wb_gnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= atop_pkg::IDLE;
      wb_gnt_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      // The write-back answers one cycle after its grant
      wb_gnt_q <= (state_q == atop_pkg::WRITE_BACK) && mem_gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q      <= sbr_addr_i;
      aid_q       <= sbr_aid_i;
      amo_op_q    <= sbr_atop_i;
      operand_b_q <= sbr_wdata_i;
    end
    if ((state_q == atop_pkg::WRITE_BACK) && mem_rvalid_i) begin
      operand_a_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/response_buffer.sv */
/*
 * Response buffer
 * Queues the IDs of accepted requests and the memory responses, and joins
 * them in order into the subordinate response channel.
 */

`timescale 1ns/1ps
`default_nettype none

module response_buffer #(
  parameter int unsigned IdWidth = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              accept_i,
  input  wire logic [IdWidth-1:0]                aid_i,
  input  wire logic                              mem_rvalid_i,
  input  wire logic                              drop_rsp_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    mem_rdata_i,
  input  wire logic                              mem_err_i,
  input  wire logic                              sc_q_i,
  input  wire logic                              sc_ok_q_i,
  input  wire logic                              sbr_rready_i,
  output logic                                   buf_ready_o,
  output logic                                   sbr_rvalid_o,
  output logic      [atop_pkg::WordWidth-1:0]    sbr_rdata_o,
  output logic                                   sbr_err_o,
  output logic                                   sbr_exokay_o,
  output logic      [IdWidth-1:0]                sbr_rid_o
);

  localparam int unsigned W          = atop_pkg::WordWidth;
  localparam int unsigned EntryWidth = W + 2;

  logic [IdWidth-1:0]    id_mem [2];
  logic                  id_wr_ptr_q, id_rd_ptr_q;
  logic [1:0]            id_cnt_q;
  logic [EntryWidth-1:0] data_mem [2];
  logic [1:0]            data_cnt_q;
  logic [EntryWidth-1:0] data_in, data_out;
  logic                  data_push, data_empty, store_push, store_pop, wr_idx, pop_rsp;

  // ---------------------------------------------------------------------
  // Data queue, fall-through
  // ---------------------------------------------------------------------

  // An SC reports 0 on success and 1 on failure instead of the read data
  assign data_in    = {mem_err_i, sc_ok_q_i,
                       sc_q_i ? {{(W-1){1'b0}}, !sc_ok_q_i} : mem_rdata_i};
  assign data_push  = mem_rvalid_i && !drop_rsp_i;
  assign data_empty = (data_cnt_q == 2'd0);
  assign data_out   = data_empty ? data_in : data_mem[0];

  assign store_pop  = pop_rsp && !data_empty;
  assign store_push = data_push && !(pop_rsp && data_empty);
  assign wr_idx     = data_cnt_q[1] | (data_cnt_q[0] & !store_pop);

  // Head always sits in slot 0, a pop shifts slot 1 down
  always_ff @(posedge clk_i) begin
    if (store_pop) begin
      data_mem[0] <= data_mem[1];
    end
    if (store_push) begin
      data_mem[wr_idx] <= data_in;
    end
  end

  // ---------------------------------------------------------------------
  // ID queue
  // ---------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      id_mem[id_wr_ptr_q] <= aid_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_wr_ptr_q <= 1'b0;
      id_rd_ptr_q <= 1'b0;
      id_cnt_q    <= 2'd0;
      data_cnt_q  <= 2'd0;
    end else begin
      if (accept_i) begin
        id_wr_ptr_q <= !id_wr_ptr_q;
      end
      if (pop_rsp) begin
        id_rd_ptr_q <= !id_rd_ptr_q;
      end
      if (accept_i && !pop_rsp) begin
        id_cnt_q <= id_cnt_q + 2'd1;
      end else if (!accept_i && pop_rsp) begin
        id_cnt_q <= id_cnt_q - 2'd1;
      end
      if (store_push && !store_pop) begin
        data_cnt_q <= data_cnt_q + 2'd1;
      end else if (!store_push && store_pop) begin
        data_cnt_q <= data_cnt_q - 2'd1;
      end
    end
  end

  // New requests wait until no response is stuck in the queue
  assign buf_ready_o  = data_empty;

  // Read data always arrives after its ID, so both must be present
  assign sbr_rvalid_o = (id_cnt_q != 2'd0) && (!data_empty || data_push);
  assign pop_rsp      = sbr_rvalid_o && sbr_rready_i;

  assign sbr_rdata_o  = data_out[W-1:0];
  assign sbr_exokay_o = data_out[W];
  assign sbr_err_o    = data_out[W+1];
  assign sbr_rid_o    = id_mem[id_rd_ptr_q];

endmodule

`default_nettype wire

/* verilog/atop_resolver.sv */
/*
 * Atomic-operation resolver
 * Sits in front of an exclusively owned memory, resolves AMOs into
 * read/write-back pairs and tracks one LR/SC reservation.
 */

`timescale 1ns/1ps
`default_nettype none

module atop_resolver #(
  parameter int unsigned AddrWidth = 16,
  parameter int unsigned IdWidth   = 4
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  // Subordinate port
  input  wire logic                              sbr_req_i,
  input  wire logic [AddrWidth-1:0]              sbr_addr_i,
  input  wire logic                              sbr_we_i,
  input  wire logic [atop_pkg::BeWidth-1:0]      sbr_be_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    sbr_wdata_i,
  input  wire logic [IdWidth-1:0]                sbr_aid_i,
  input  atop_pkg::atop_e                        sbr_atop_i,
  output logic                                   sbr_gnt_o,
  output logic                                   sbr_rvalid_o,
  input  wire logic                              sbr_rready_i,
  output logic      [atop_pkg::WordWidth-1:0]    sbr_rdata_o,
  output logic                                   sbr_err_o,
  output logic                                   sbr_exokay_o,
  output logic      [IdWidth-1:0]                sbr_rid_o,
  // Memory port
  output logic                                   mem_req_o,
  output logic      [AddrWidth-1:0]              mem_addr_o,
  output logic                                   mem_we_o,
  output logic      [atop_pkg::BeWidth-1:0]      mem_be_o,
  output logic      [atop_pkg::WordWidth-1:0]    mem_wdata_o,
  output logic      [IdWidth-1:0]                mem_aid_o,
  input  wire logic                              mem_gnt_i,
  input  wire logic                              mem_rvalid_i,
  input  wire logic [atop_pkg::WordWidth-1:0]    mem_rdata_i,
  input  wire logic                              mem_err_i
);

  logic                           accept, drop_rsp, buf_ready;
  logic                           sc_pass, sc_q, sc_ok_q;
  atop_pkg::atop_e                amo_op;
  logic [atop_pkg::WordWidth-1:0] operand_a, operand_b, alu_result;

  amo_sequencer #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth)
  ) u_sequencer (
    .clk_i, .rst_ni,
    .sbr_req_i, .sbr_addr_i, .sbr_we_i, .sbr_be_i, .sbr_wdata_i, .sbr_aid_i, .sbr_atop_i,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i,
    .buf_ready_i  (buf_ready),
    .sc_pass_i    (sc_pass),
    .alu_result_i (alu_result),
    .sbr_gnt_o,
    .mem_req_o, .mem_addr_o, .mem_we_o, .mem_be_o, .mem_wdata_o, .mem_aid_o,
    .accept_o     (accept),
    .drop_rsp_o   (drop_rsp),
    .amo_op_o     (amo_op),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b)
  );

  amo_alu u_alu (
    .amo_op_i    (amo_op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .result_o    (alu_result)
  );

  reservation_tracker #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth)
  ) u_reservation (
    .clk_i, .rst_ni,
    .accept_i  (accept),
    .addr_i    (sbr_addr_i),
    .aid_i     (sbr_aid_i),
    .we_i      (sbr_we_i),
    .atop_i    (sbr_atop_i),
    .sc_pass_o (sc_pass),
    .sc_q_o    (sc_q),
    .sc_ok_q_o (sc_ok_q)
  );

  response_buffer #(
    .IdWidth (IdWidth)
  ) u_rsp_buffer (
    .clk_i, .rst_ni,
    .accept_i    (accept),
    .aid_i       (sbr_aid_i),
    .mem_rvalid_i, .mem_rdata_i, .mem_err_i,
    .drop_rsp_i  (drop_rsp),
    .sc_q_i      (sc_q),
    .sc_ok_q_i   (sc_ok_q),
    .sbr_rready_i,
    .buf_ready_o (buf_ready),
    .sbr_rvalid_o, .sbr_rdata_o, .sbr_err_o, .sbr_exokay_o, .sbr_rid_o
  );

endmodule

`default_nettype wire

/* verification/atop_resolver_properties.sv */
/*
 * Sequencer properties
 * Handshake and write-back rules of the AMO sequencer, bound into it.
 */

`timescale 1ns/1ps
`default_nettype none

module atop_resolver_properties (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  atop_pkg::amo_state_e state_i,
  input  wire logic           sbr_gnt_i,
  input  wire logic           mem_req_i,
  input  wire logic           mem_we_i
);

  // A new request is only granted while no write-back is pending
  gnt_only_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sbr_gnt_i |-> (state_i == atop_pkg::IDLE))
    else $error("Request granted while the sequencer was not idle");

  wb_is_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == atop_pkg::WRITE_BACK) |-> (mem_req_i && mem_we_i))
    else $error("Write-back state without a memory write request");

  idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (state_i == atop_pkg::IDLE))
    else $error("Sequencer not idle when reset was released");

endmodule

bind amo_sequencer atop_resolver_properties u_properties (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .state_i   (state_q),
  .sbr_gnt_i (sbr_gnt_o),
  .mem_req_i (mem_req_o),
  .mem_we_i  (mem_we_o)
);

`default_nettype wire

/* verification/tb_atop_resolver.sv */
/*
 * Testbench for the atomic-operation resolver
 * Directed tests with a memory model, a reference model of memory and
 * reservation, response checks and a watchdog.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_atop_resolver;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned W         = atop_pkg::WordWidth;
  localparam logic [31:0] Seed      = 32'hd40b_066b;
  localparam int          RandOps   = 40;
  // Sum of the requests issued by all tests
  localparam int          NumOps    = 10 + 27 + 8 + 4 + RandOps;
  localparam int          OpBound   = 40;

  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [W-1:0]       data;
    logic               exokay;
  } rsp_t;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic                         sbr_req_i, sbr_we_i;
  logic [AddrWidth-1:0]         sbr_addr_i;
  logic [atop_pkg::BeWidth-1:0] sbr_be_i;
  logic [W-1:0]                 sbr_wdata_i;
  logic [IdWidth-1:0]           sbr_aid_i;
  atop_pkg::atop_e              sbr_atop_i;
  logic                         sbr_gnt_o, sbr_rvalid_o, sbr_err_o, sbr_exokay_o;
  logic                         sbr_rready_i = 1'b1;
  logic [W-1:0]                 sbr_rdata_o;
  logic [IdWidth-1:0]           sbr_rid_o;
  logic                         mem_req_o, mem_we_o;
  logic [AddrWidth-1:0]         mem_addr_o;
  logic [atop_pkg::BeWidth-1:0] mem_be_o;
  logic [W-1:0]                 mem_wdata_o;
  logic [IdWidth-1:0]           mem_aid_o;
  logic                         mem_gnt_i    = 1'b0;
  logic                         mem_rvalid_i = 1'b0;
  logic [W-1:0]                 mem_rdata_i  = '0;
  logic                         mem_err_i    = 1'b0;

  logic [W-1:0]         mem [256];
  logic [W-1:0]         ref_mem [256];
  logic                 rsp_pend_q = 1'b0;
  logic [W-1:0]         rsp_data_q = '0;
  logic [31:0]          stim_rng   = Seed;
  logic [31:0]          model_rng  = {Seed[15:0], Seed[31:16]};
  int                   accept_cnt = 0;
  int                   stall_cnt  = 0;
  logic                 stall_en   = 1'b0;
  logic [IdWidth-1:0]   last_aid   = '0;
  logic                 resv_valid;
  logic [AddrWidth-1:0] resv_addr;
  logic [IdWidth-1:0]   resv_owner;
  string                cur_test   = "reset";
  rsp_t                 exp_q [$];
  atop_pkg::atop_e      amo_q [$];
  atop_pkg::atop_e      rmw_ops [9] = '{atop_pkg::AMO_SWAP, atop_pkg::AMO_ADD, atop_pkg::AMO_XOR,
                                        atop_pkg::AMO_AND, atop_pkg::AMO_OR, atop_pkg::AMO_MIN,
                                        atop_pkg::AMO_MAX, atop_pkg::AMO_MINU, atop_pkg::AMO_MAXU};

  atop_resolver #(
    .AddrWidth (AddrWidth),
    .IdWidth   (IdWidth)
  ) UUT (.*);

  always #5 clk_i = ~clk_i;

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [W-1:0] fill_word(input int i);
    return 32'h9e37_79b9 * 32'(i + 1);
  endfunction

  function automatic logic [W-1:0] merge_bytes(input logic [W-1:0] old_v, new_v,
                                               input logic [3:0] be);
    logic [W-1:0] v;
    v = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) v[8*b +: 8] = new_v[8*b +: 8];
    end
    return v;
  endfunction

  // Write-back value per the RISC-V AMO definitions
  function automatic logic [W-1:0] alu_model(input atop_pkg::atop_e op, input logic [W-1:0] a, b);
    case (op)
      atop_pkg::AMO_SWAP: return b;
      atop_pkg::AMO_ADD:  return a + b;
      atop_pkg::AMO_XOR:  return a ^ b;
      atop_pkg::AMO_AND:  return a & b;
      atop_pkg::AMO_OR:   return a | b;
      atop_pkg::AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      atop_pkg::AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      atop_pkg::AMO_MINU: return (a < b) ? a : b;
      atop_pkg::AMO_MAXU: return (a > b) ? a : b;
      default:            return '0;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic data_cmp(input string what, input logic [W-1:0] exp, act);
    if (act !== exp) abort_run($sformatf("ERROR %s: %s expected %h, actual %h",
                                         cur_test, what, exp, act));
  endtask

  task automatic id_cmp(input string what, input logic [IdWidth-1:0] exp, act);
    if (act !== exp) abort_run($sformatf("ERROR %s: %s expected %h, actual %h",
                                         cur_test, what, exp, act));
  endtask

  task automatic flag_cmp(input string what, input logic exp, act);
    if (act !== exp) abort_run($sformatf("ERROR %s: %s expected %b, actual %b",
                                         cur_test, what, exp, act));
  endtask

  task automatic opcode_cmp(input atop_pkg::atop_e exp, act);
    if (act !== exp) abort_run($sformatf("ERROR %s: write-back opcode expected %s, actual %s",
                                         cur_test, exp.name(), act.name()));
  endtask

  // Reference model of memory and the single reservation
  task automatic predict_rsp(input logic [AddrWidth-1:0] addr, input logic we,
                             input logic [3:0] be, input logic [W-1:0] wdata,
                             input logic [IdWidth-1:0] aid, input atop_pkg::atop_e atop);
    rsp_t       rsp;
    logic [7:0] idx;
    logic       own, pass;
    idx  = addr[7:0];
    own  = resv_valid && (resv_owner == aid);
    rsp  = '{id: aid, data: '0, exokay: 1'b0};
    case (atop)
      atop_pkg::ATOP_NONE: begin
        if (we) ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
        else rsp.data = ref_mem[idx];
      end
      atop_pkg::AMO_LR: begin
        rsp.data = ref_mem[idx];
        if (!resv_valid || own) begin
          resv_valid = 1'b1;
          resv_addr  = addr;
          resv_owner = aid;
          rsp.exokay = 1'b1;
        end
      end
      atop_pkg::AMO_SC: begin
        pass = own && (resv_addr == addr);
        if (own) resv_valid = 1'b0;
        if (pass) ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
        rsp.data   = {31'd0, !pass};
        rsp.exokay = pass;
      end
      default: begin
        rsp.data     = ref_mem[idx];
        ref_mem[idx] = alu_model(atop, ref_mem[idx], wdata);
        amo_q.push_back(atop);
      end
    endcase
    // A write or AMO by another requester to the reserved word breaks it
    if ((atop != atop_pkg::AMO_LR) && (atop != atop_pkg::AMO_SC) &&
        (we || atop != atop_pkg::ATOP_NONE) && (resv_owner != aid) && (resv_addr == addr)) begin
      resv_valid = 1'b0;
    end
    exp_q.push_back(rsp);
  endtask

  task automatic send_req(input logic [AddrWidth-1:0] addr, input logic we,
                          input logic [3:0] be, input logic [W-1:0] wdata,
                          input logic [IdWidth-1:0] aid, input atop_pkg::atop_e atop);
    int start;
    start = accept_cnt;
    predict_rsp(addr, we, be, wdata, aid, atop);
    sbr_req_i   = 1'b1;
    sbr_addr_i  = addr;
    sbr_we_i    = we;
    sbr_be_i    = be;
    sbr_wdata_i = wdata;
    sbr_aid_i   = aid;
    sbr_atop_i  = atop;
    do @(negedge clk_i); while (accept_cnt == start);
    sbr_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || amo_q.size() != 0) @(negedge clk_i);
  endtask

  // ---------------------------------------------------------------------
  // Memory model and response monitor
  // ---------------------------------------------------------------------

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 256; i++) mem[i] <= fill_word(i);
    end else if (mem_req_o && mem_gnt_i) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_we_o && mem_be_o[b]) mem[mem_addr_o[7:0]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
      end
      rsp_data_q <= mem_we_o ? '0 : mem[mem_addr_o[7:0]];
    end
    rsp_pend_q <= rst_ni && mem_req_o && mem_gnt_i;
  end

  always @(negedge clk_i) begin
    model_rng    = xorshift(model_rng);
    mem_gnt_i    = (model_rng[1:0] != 2'b00);
    mem_rvalid_i = rsp_pend_q;
    mem_rdata_i  = rsp_data_q;
    if (stall_cnt != 0) begin
      sbr_rready_i = 1'b0;
      stall_cnt    = stall_cnt - 1;
    end else begin
      sbr_rready_i = 1'b1;
      if (stall_en && model_rng[7:5] == 3'd0) stall_cnt = int'(model_rng[11:8]) + 1;
    end
  end

  always @(posedge clk_i) begin
    rsp_t want;
    if (sbr_req_i && sbr_gnt_o) accept_cnt <= accept_cnt + 1;
    // A memory access without a new request is the write-back of the last AMO
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      id_cmp("mem_aid", (sbr_req_i && sbr_gnt_o) ? sbr_aid_i : last_aid, mem_aid_o);
    end
    if (sbr_req_i && sbr_gnt_o) last_aid = sbr_aid_i;
    if (sbr_rvalid_o && sbr_rready_i) begin
      if (exp_q.size() == 0) abort_run("A response arrived with no request outstanding");
      want = exp_q.pop_front();
      id_cmp("rid", want.id, sbr_rid_o);
      data_cmp("rdata", want.data, sbr_rdata_o);
      flag_cmp("exokay", want.exokay, sbr_exokay_o);
      flag_cmp("err", 1'b0, sbr_err_o);
    end
    if (UUT.u_sequencer.state_q == atop_pkg::WRITE_BACK && mem_gnt_i) begin
      if (amo_q.size() == 0) abort_run("A write-back happened with no AMO outstanding");
      opcode_cmp(amo_q.pop_front(), UUT.u_sequencer.amo_op_o);
    end
  end

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------

  task automatic plain_rw_test();
    cur_test = "plain_rw";
    for (int i = 0; i < 4; i++) begin
      stim_rng = xorshift(stim_rng);
      send_req(16'h0010 + 16'(i), 1'b1, 4'hF, stim_rng, IdWidth'(i), atop_pkg::ATOP_NONE);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(16'h0010 + 16'(i), 1'b0, 4'hF, '0, IdWidth'(i + 4), atop_pkg::ATOP_NONE);
    end
    send_req(16'h0010, 1'b1, 4'b0101, 32'ha5a5_a5a5, 4'd9, atop_pkg::ATOP_NONE);
    send_req(16'h0010, 1'b0, 4'hF, '0, 4'd10, atop_pkg::ATOP_NONE);
    wait_idle();
  endtask

  task automatic amo_test();
    logic [W-1:0] init_v [9];
    logic [W-1:0] oper_v [9];
    cur_test = "amo";
    init_v = '{32'h1234_5678, 32'hffff_ffff, 32'hdead_beef, 32'hf0f0_f0f0, 32'h0f0f_0000,
               32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
    oper_v = '{32'hcafe_f00d, 32'h0000_0002, 32'hffff_0000, 32'h3c3c_3c3c, 32'h00ff_00ff,
               32'h7fff_ffff, 32'h7fff_ffff, 32'h7fff_ffff, 32'h8000_0000};
    for (int i = 0; i < 9; i++) begin
      send_req(16'h0080 + 16'(i), 1'b1, 4'hF, init_v[i], 4'd3, atop_pkg::ATOP_NONE);
      send_req(16'h0080 + 16'(i), 1'b1, 4'hF, oper_v[i], 4'd4, rmw_ops[i]);
      send_req(16'h0080 + 16'(i), 1'b0, 4'hF, '0, 4'd5, atop_pkg::ATOP_NONE);
    end
    wait_idle();
  endtask

  task automatic lr_sc_test();
    cur_test = "lr_sc";
    send_req(16'h0020, 1'b0, 4'hF, '0, 4'd1, atop_pkg::AMO_LR);
    send_req(16'h0020, 1'b1, 4'hF, 32'h1111_2222, 4'd1, atop_pkg::AMO_SC);
    send_req(16'h0020, 1'b0, 4'hF, '0, 4'd1, atop_pkg::ATOP_NONE);
    // No reservation is left, then a reservation on a different word
    send_req(16'h0020, 1'b1, 4'hF, 32'h3333_4444, 4'd1, atop_pkg::AMO_SC);
    send_req(16'h0020, 1'b0, 4'hF, '0, 4'd1, atop_pkg::ATOP_NONE);
    send_req(16'h0021, 1'b0, 4'hF, '0, 4'd1, atop_pkg::AMO_LR);
    send_req(16'h0022, 1'b1, 4'hF, 32'h5555_6666, 4'd1, atop_pkg::AMO_SC);
    send_req(16'h0022, 1'b0, 4'hF, '0, 4'd1, atop_pkg::ATOP_NONE);
    wait_idle();
  endtask

  task automatic resv_break_test();
    cur_test = "resv_break";
    send_req(16'h0030, 1'b0, 4'hF, '0, 4'd1, atop_pkg::AMO_LR);
    send_req(16'h0030, 1'b1, 4'hF, 32'h0bad_0bad, 4'd2, atop_pkg::ATOP_NONE);
    send_req(16'h0030, 1'b1, 4'hF, 32'h7777_8888, 4'd1, atop_pkg::AMO_SC);
    send_req(16'h0030, 1'b0, 4'hF, '0, 4'd1, atop_pkg::ATOP_NONE);
    wait_idle();
  endtask

  task automatic backpressure_test();
    logic [31:0]     r;
    logic            we;
    atop_pkg::atop_e op;
    cur_test = "backpressure";
    stall_en = 1'b1;
    for (int n = 0; n < RandOps; n++) begin
      stim_rng = xorshift(stim_rng);
      r  = stim_rng;
      we = 1'b0;
      op = atop_pkg::ATOP_NONE;
      case (r[2:0])
        3'd0, 3'd1: we = 1'b1;
        3'd4, 3'd7: begin
          op = rmw_ops[int'(r[7:4]) % 9];
          we = 1'b1;
        end
        3'd5: op = atop_pkg::AMO_LR;
        3'd6: begin
          op = atop_pkg::AMO_SC;
          we = 1'b1;
        end
        default: ;
      endcase
      send_req(16'h0040 + 16'(r[10:8]), we, (op == atop_pkg::ATOP_NONE) ? r[15:12] : 4'hF,
               xorshift(r), IdWidth'(r[17:16]), op);
    end
    stall_en = 1'b0;
    wait_idle();
  endtask

  initial begin
    #(NumOps * OpBound * 10);
    abort_run("Timeout: the DUT stopped answering before all tests finished");
  end

  initial begin
    rst_ni      = 1'b0;
    sbr_req_i   = 1'b0;
    sbr_addr_i  = '0;
    sbr_we_i    = 1'b0;
    sbr_be_i    = '0;
    sbr_wdata_i = '0;
    sbr_aid_i   = '0;
    sbr_atop_i  = atop_pkg::ATOP_NONE;
    resv_valid  = 1'b0;
    resv_addr   = '0;
    resv_owner  = '0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(i);
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    plain_rw_test();
    amo_test();
    lr_sc_test();
    resv_break_test();
    backpressure_test();
    if (exp_q.size() == 0 && amo_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("Responses or write-backs were still outstanding at the end");
    end
  end

endmodule

`default_nettype wire

/* src.f */
verilog/atop_pkg.sv
verilog/amo_alu.sv
verilog/reservation_tracker.sv
verilog/amo_sequencer.sv
verilog/response_buffer.sv
verilog/atop_resolver.sv
verification/atop_resolver_properties.sv
verification/tb_atop_resolver.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the atomic resolver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_atop_resolver \
  -f src.f \
  -Mdir obj_dir \
  -o tb_atop_resolver
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit $status
fi

./obj_dir/tb_atop_resolver
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit $status
fi

exit 0
